// ==== common/demux_cfg_pkg.sv ====
package demux_cfg_pkg;

  // ------------------------------------------------------------------
  // port selection
  // ------------------------------------------------------------------

  // select width covers up to four master ports
  localparam int unsigned PORT_SEL_W = 2;

  // index of one master port
  typedef logic [PORT_SEL_W-1:0] port_sel_t;

  // ------------------------------------------------------------------
  // structural defaults
  // ------------------------------------------------------------------

  // master ports behind the demux, legal range 2 to 4
  localparam int unsigned DEF_NUM_PORTS = 4;

  // low id bits that pick an id slot
  // 2 bits give 4 slots, ids sharing these bits share a slot
  localparam int unsigned DEF_LOOK_BITS = 2;

  // in-flight counter width per slot
  // all ones counts as full and stalls new requests
  localparam int unsigned DEF_CNT_W = 3;

  // one in-flight burst count
  typedef logic [DEF_CNT_W-1:0] cnt_t;

endpackage

// ==== common/axi_rd_pkg.sv ====
package axi_rd_pkg;

  // ------------------------------------------------------------------
  // read channel fields
  // ------------------------------------------------------------------

  // transaction id
  localparam int unsigned ID_W = 4;
  typedef logic [ID_W-1:0] id_t;

  // byte address on AR
  localparam int unsigned ADDR_W = 32;
  typedef logic [ADDR_W-1:0] addr_t;

  // burst length, beats minus one as on the bus
  typedef logic [7:0] len_t;

  // one R data word
  localparam int unsigned DATA_W = 32;
  typedef logic [DATA_W-1:0] data_t;

  // ------------------------------------------------------------------
  // control state encodings
  // ------------------------------------------------------------------

  // AR_LOCKED holds an offered request until the port takes it
  typedef enum logic {AR_IDLE, AR_LOCKED} ar_state_e;

  // R_BURST keeps the merger on one port until its last beat
  typedef enum logic {R_ARB, R_BURST} r_state_e;

endpackage

// ==== rtl/id_slot.sv ====
`timescale 1ns/100ps

module id_slot #(
  parameter int unsigned CNT_W = $bits(demux_cfg_pkg::cnt_t)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // one burst accepted for this id
  input  logic                     push_i,
  // last beat of one burst handed over
  input  logic                     pop_i,
  // port the pushed burst went to
  input  demux_cfg_pkg::port_sel_t push_sel_i,
  output logic                     occupied_o,
  output logic                     full_o,
  output demux_cfg_pkg::port_sel_t sel_o
);
  import demux_cfg_pkg::*;

  logic [CNT_W-1:0] cnt_q;
  port_sel_t        sel_q;

  // ------------------------------------------------------------------
  // in-flight counter
  // ------------------------------------------------------------------

  // push and pop together leave the count as is
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (push_i && !pop_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (pop_i && !push_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // port of the bursts in flight, only read while occupied
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      sel_q <= push_sel_i;
    end
  end

  assign occupied_o = |cnt_q;
  // all ones means no room for another burst
  assign full_o     = &cnt_q;
  assign sel_o      = sel_q;

endmodule

// ==== rd_demux/ar_route.sv ====
`timescale 1ns/100ps

module ar_route #(
  parameter int unsigned NUM_PORTS = demux_cfg_pkg::DEF_NUM_PORTS,
  parameter int unsigned LOOK_BITS = demux_cfg_pkg::DEF_LOOK_BITS
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  // slave request and its port select
  input  logic                                        s_ar_valid_i,
  input  axi_rd_pkg::id_t                             s_ar_id_i,
  input  demux_cfg_pkg::port_sel_t                    s_ar_sel_i,
  output logic                                        s_ar_ready_o,
  // steered valids and returned readies
  output logic                      [NUM_PORTS-1:0]   m_ar_valid_o,
  input  logic                      [NUM_PORTS-1:0]   m_ar_ready_i,
  // state of every id slot
  input  logic                      [2**LOOK_BITS-1:0] slot_occupied_i,
  input  logic                      [2**LOOK_BITS-1:0] slot_full_i,
  input  demux_cfg_pkg::port_sel_t  [2**LOOK_BITS-1:0] slot_sel_i,
  // one-hot push on every accepted request
  output logic                      [2**LOOK_BITS-1:0] slot_push_o,
  output demux_cfg_pkg::port_sel_t                    push_sel_o
);
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int unsigned NUM_SLOTS = 2**LOOK_BITS;

  ar_state_e            state_q;
  ar_state_e            state_d;
  logic [LOOK_BITS-1:0] slot_idx;
  port_sel_t            lookup_sel;
  logic                 lookup_occupied;
  logic                 any_full;
  logic                 admit;
  logic                 sel_ready;
  logic                 ar_valid;
  logic                 ar_hs;

  // ------------------------------------------------------------------
  // id lookup
  // ------------------------------------------------------------------

  // slot picked by the low id bits
  assign slot_idx        = s_ar_id_i[LOOK_BITS-1:0];
  assign lookup_occupied = slot_occupied_i[slot_idx];
  assign lookup_sel      = slot_sel_i[slot_idx];
  // any full slot blocks all new requests
  assign any_full        = |slot_full_i;

  // same id may only go where its earlier bursts went
  assign admit = !any_full && (!lookup_occupied || (lookup_sel == s_ar_sel_i));

  // ready of the selected port, out-of-range selects never see ready
  always_comb begin
    sel_ready = 1'b0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (s_ar_sel_i == p) begin
        sel_ready = m_ar_ready_i[p];
      end
    end
  end

  // ------------------------------------------------------------------
  // valid lock FSM
  // ------------------------------------------------------------------

  always_comb begin
    state_d  = state_q;
    ar_valid = 1'b0;
    case (state_q)
      AR_IDLE: begin
        // offer only admitted requests
        if (s_ar_valid_i && admit) begin
          ar_valid = 1'b1;
          // not taken yet, keep offering whatever the slots do next
          if (!sel_ready) begin
            state_d = AR_LOCKED;
          end
        end
      end
      AR_LOCKED: begin
        // offer stays up until the port accepts
        ar_valid = 1'b1;
        if (sel_ready) begin
          state_d = AR_IDLE;
        end
      end
      default: state_d = AR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= AR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------------
  // steering and push
  // ------------------------------------------------------------------

  assign ar_hs        = ar_valid & sel_ready;
  assign s_ar_ready_o = ar_hs;

  // valid to the selected port only
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      m_ar_valid_o[p] = ar_valid && (s_ar_sel_i == p);
    end
  end

  // count the burst in its slot on the handshake edge
  always_comb begin
    for (int unsigned s = 0; s < NUM_SLOTS; s++) begin
      slot_push_o[s] = ar_hs && (slot_idx == s);
    end
  end
  assign push_sel_o = s_ar_sel_i;

endmodule

// ==== rd_demux/r_merge.sv ====
`timescale 1ns/100ps

module r_merge #(
  parameter int unsigned NUM_PORTS = demux_cfg_pkg::DEF_NUM_PORTS,
  parameter int unsigned LOOK_BITS = demux_cfg_pkg::DEF_LOOK_BITS
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  // response beats from the master ports
  input  logic              [NUM_PORTS-1:0]       m_r_valid_i,
  input  axi_rd_pkg::id_t   [NUM_PORTS-1:0]       m_r_id_i,
  input  axi_rd_pkg::data_t [NUM_PORTS-1:0]       m_r_data_i,
  input  logic              [NUM_PORTS-1:0]       m_r_last_i,
  output logic              [NUM_PORTS-1:0]       m_r_ready_o,
  // merged stream to the slave
  output logic                                    s_r_valid_o,
  output axi_rd_pkg::id_t                         s_r_id_o,
  output axi_rd_pkg::data_t                       s_r_data_o,
  output logic                                    s_r_last_o,
  input  logic                                    s_r_ready_i,
  // one-hot release of a slot on each handed-over last beat
  output logic              [2**LOOK_BITS-1:0]    slot_pop_o
);
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int unsigned NUM_SLOTS = 2**LOOK_BITS;

  r_state_e  state_q;
  r_state_e  state_d;
  port_sel_t rr_q;     // first port to search
  port_sel_t rr_d;
  port_sel_t burst_q;  // port owning the stream in R_BURST
  port_sel_t burst_d;
  port_sel_t arb_idx;
  port_sel_t gnt_idx;
  logic      arb_found;
  logic      gnt_valid;
  logic      r_hs;
  logic      r_done;

  // ------------------------------------------------------------------
  // round-robin search
  // ------------------------------------------------------------------

  always_comb begin : rr_search
    int unsigned cand;
    arb_found = 1'b0;
    arb_idx   = rr_q;
    for (int unsigned k = 0; k < NUM_PORTS; k++) begin
      // wrap around behind the last port
      cand = rr_q + k;
      if (cand >= NUM_PORTS) begin
        cand = cand - NUM_PORTS;
      end
      if (!arb_found && m_r_valid_i[cand]) begin
        arb_found = 1'b1;
        arb_idx   = port_sel_t'(cand);
      end
    end
  end

  // locked port wins outright, else the search result
  assign gnt_valid = (state_q == R_BURST) || arb_found;
  assign gnt_idx   = (state_q == R_BURST) ? burst_q : arb_idx;

  // ------------------------------------------------------------------
  // forwarding
  // ------------------------------------------------------------------

  always_comb begin
    if (gnt_valid) begin
      s_r_valid_o = m_r_valid_i[gnt_idx];
      s_r_id_o    = m_r_id_i[gnt_idx];
      s_r_data_o  = m_r_data_i[gnt_idx];
      s_r_last_o  = m_r_last_i[gnt_idx];
    end else begin
      s_r_valid_o = 1'b0;
      s_r_id_o    = '0;
      s_r_data_o  = '0;
      s_r_last_o  = 1'b0;
    end
  end

  // slave ready goes back to the granted port only
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      m_r_ready_o[p] = gnt_valid && s_r_ready_i && (gnt_idx == p);
    end
  end

  assign r_hs   = s_r_valid_o & s_r_ready_i;
  assign r_done = r_hs & s_r_last_o;

  // ------------------------------------------------------------------
  // burst lock FSM
  // ------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    burst_d = burst_q;
    rr_d    = rr_q;
    case (state_q)
      R_ARB: begin
        // stay on the winner unless its single beat is already gone
        // a stalled beat also locks, so the offered payload holds
        if (arb_found && !r_done) begin
          state_d = R_BURST;
          burst_d = arb_idx;
        end
      end
      R_BURST: begin
        if (r_done) begin
          state_d = R_ARB;
        end
      end
      default: state_d = R_ARB;
    endcase
    // search resumes behind the port whose burst just ended
    if (r_done) begin
      rr_d = (gnt_idx == port_sel_t'(NUM_PORTS - 1)) ? '0 : port_sel_t'(gnt_idx + 1'b1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= R_ARB;
      rr_q    <= '0;
      burst_q <= '0;
    end else begin
      state_q <= state_d;
      rr_q    <= rr_d;
      burst_q <= burst_d;
    end
  end

  // release the slot named by the low id bits of the last beat
  always_comb begin
    for (int unsigned s = 0; s < NUM_SLOTS; s++) begin
      slot_pop_o[s] = r_done && (s_r_id_o[LOOK_BITS-1:0] == s);
    end
  end

endmodule

// ==== rd_demux/rd_demux_top.sv ====
`timescale 1ns/100ps

module rd_demux_top #(
  parameter int unsigned NUM_PORTS = demux_cfg_pkg::DEF_NUM_PORTS,
  parameter int unsigned LOOK_BITS = demux_cfg_pkg::DEF_LOOK_BITS,
  parameter int unsigned CNT_W     = demux_cfg_pkg::DEF_CNT_W
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  // slave AR
  input  logic                                      s_ar_valid_i,
  input  axi_rd_pkg::id_t                           s_ar_id_i,
  input  axi_rd_pkg::addr_t                         s_ar_addr_i,
  input  axi_rd_pkg::len_t                          s_ar_len_i,
  input  demux_cfg_pkg::port_sel_t                  s_ar_sel_i,
  output logic                                      s_ar_ready_o,
  // slave R
  output logic                                      s_r_valid_o,
  output axi_rd_pkg::id_t                           s_r_id_o,
  output axi_rd_pkg::data_t                         s_r_data_o,
  output logic                                      s_r_last_o,
  input  logic                                      s_r_ready_i,
  // master AR, one element per port
  output logic                    [NUM_PORTS-1:0]   m_ar_valid_o,
  output axi_rd_pkg::id_t         [NUM_PORTS-1:0]   m_ar_id_o,
  output axi_rd_pkg::addr_t       [NUM_PORTS-1:0]   m_ar_addr_o,
  output axi_rd_pkg::len_t        [NUM_PORTS-1:0]   m_ar_len_o,
  input  logic                    [NUM_PORTS-1:0]   m_ar_ready_i,
  // master R, one element per port
  input  logic                    [NUM_PORTS-1:0]   m_r_valid_i,
  input  axi_rd_pkg::id_t         [NUM_PORTS-1:0]   m_r_id_i,
  input  axi_rd_pkg::data_t       [NUM_PORTS-1:0]   m_r_data_i,
  input  logic                    [NUM_PORTS-1:0]   m_r_last_i,
  output logic                    [NUM_PORTS-1:0]   m_r_ready_o
);
  import demux_cfg_pkg::*;

  localparam int unsigned NUM_SLOTS = 2**LOOK_BITS;

  // slot strobes and lookup results
  logic      [NUM_SLOTS-1:0] slot_push;
  logic      [NUM_SLOTS-1:0] slot_pop;
  logic      [NUM_SLOTS-1:0] slot_occupied;
  logic      [NUM_SLOTS-1:0] slot_full;
  port_sel_t [NUM_SLOTS-1:0] slot_sel;
  port_sel_t                 push_sel;

  // ------------------------------------------------------------------
  // AR side
  // ------------------------------------------------------------------

  ar_route #(
    .NUM_PORTS (NUM_PORTS),
    .LOOK_BITS (LOOK_BITS)
  ) i_ar_route (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .s_ar_valid_i    (s_ar_valid_i),
    .s_ar_id_i       (s_ar_id_i),
    .s_ar_sel_i      (s_ar_sel_i),
    .s_ar_ready_o    (s_ar_ready_o),
    .m_ar_valid_o    (m_ar_valid_o),
    .m_ar_ready_i    (m_ar_ready_i),
    .slot_occupied_i (slot_occupied),
    .slot_full_i     (slot_full),
    .slot_sel_i      (slot_sel),
    .slot_push_o     (slot_push),
    .push_sel_o      (push_sel)
  );

  // request payload fans out to every port, only valid is steered
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_ar_fanout
    assign m_ar_id_o[p]   = s_ar_id_i;
    assign m_ar_addr_o[p] = s_ar_addr_i;
    assign m_ar_len_o[p]  = s_ar_len_i;
  end

  // ------------------------------------------------------------------
  // per-id slots
  // ------------------------------------------------------------------

  for (genvar s = 0; s < NUM_SLOTS; s++) begin : gen_slot
    id_slot #(
      .CNT_W (CNT_W)
    ) i_id_slot (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .push_i     (slot_push[s]),
      .pop_i      (slot_pop[s]),
      .push_sel_i (push_sel),
      .occupied_o (slot_occupied[s]),
      .full_o     (slot_full[s]),
      .sel_o      (slot_sel[s])
    );
  end

  // ------------------------------------------------------------------
  // R side
  // ------------------------------------------------------------------

  r_merge #(
    .NUM_PORTS (NUM_PORTS),
    .LOOK_BITS (LOOK_BITS)
  ) i_r_merge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_last_i  (m_r_last_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_id_o    (s_r_id_o),
    .s_r_data_o  (s_r_data_o),
    .s_r_last_o  (s_r_last_o),
    .s_r_ready_i (s_r_ready_i),
    .slot_pop_o  (slot_pop)
  );

endmodule

// ==== verif/rd_demux_chk.sv ====
`timescale 1ns/100ps

module rd_demux_chk #(
  parameter int unsigned NUM_PORTS = demux_cfg_pkg::DEF_NUM_PORTS
) (
  input logic                                clk_i,
  input logic                                reset_i,
  // master AR as seen at the top level
  input logic              [NUM_PORTS-1:0]   m_ar_valid_i,
  input logic              [NUM_PORTS-1:0]   m_ar_ready_i,
  input axi_rd_pkg::id_t   [NUM_PORTS-1:0]   m_ar_id_i,
  input axi_rd_pkg::addr_t [NUM_PORTS-1:0]   m_ar_addr_i,
  input axi_rd_pkg::len_t  [NUM_PORTS-1:0]   m_ar_len_i,
  input logic              [NUM_PORTS-1:0]   m_r_ready_i,
  // merged R stream
  input logic                                s_r_valid_i,
  input logic                                s_r_ready_i,
  input axi_rd_pkg::id_t                     s_r_id_i,
  input axi_rd_pkg::data_t                   s_r_data_i,
  input logic                                s_r_last_i
);
  int unsigned fail_cnt = 0;

  // ------------------------------------------------------------------
  // stability under back-pressure
  // ------------------------------------------------------------------

  // an offered request keeps valid and payload until taken
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_ar_stable
    assert property (@(posedge clk_i) disable iff (reset_i)
      m_ar_valid_i[p] && !m_ar_ready_i[p] |=>
        m_ar_valid_i[p] && $stable({m_ar_id_i[p], m_ar_addr_i[p], m_ar_len_i[p]}))
      else begin
        fail_cnt++;
        $error("m_ar_valid_o[%0d] dropped or payload changed before ready", p);
      end
  end

  // a stalled R beat holds as well
  assert property (@(posedge clk_i) disable iff (reset_i)
    s_r_valid_i && !s_r_ready_i |=> s_r_valid_i && $stable({s_r_id_i, s_r_data_i, s_r_last_i}))
    else begin
      fail_cnt++;
      $error("s_r_valid_o dropped or payload changed before ready");
    end

  // steering never offers or accepts on two ports at once
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(m_ar_valid_i))
    else begin
      fail_cnt++;
      $error("more than one m_ar_valid_o high");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(m_r_ready_i))
    else begin
      fail_cnt++;
      $error("more than one m_r_ready_o high");
    end

endmodule

// ==== verif/tb_rd_demux.sv ====
`timescale 1ns/100ps

module tb_rd_demux;
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;

  localparam int NP         = DEF_NUM_PORTS;
  localparam int NS         = 2**DEF_LOOK_BITS;
  localparam int CNT_MAX    = 2**DEF_CNT_W - 1;
  localparam int NUM_AR     = 300;
  localparam int DEPTH      = 64;
  localparam int CLK_PERIOD = 8;

  logic clk = 1'b0;
  logic reset;
  // slave side
  logic      s_ar_valid;
  id_t       s_ar_id;
  addr_t     s_ar_addr;
  len_t      s_ar_len;
  port_sel_t s_ar_sel;
  logic      s_ar_ready;
  logic      s_r_valid;
  id_t       s_r_id;
  data_t     s_r_data;
  logic      s_r_last;
  logic      s_r_ready;
  // master side
  logic  [NP-1:0] m_ar_valid;
  id_t   [NP-1:0] m_ar_id;
  addr_t [NP-1:0] m_ar_addr;
  len_t  [NP-1:0] m_ar_len;
  logic  [NP-1:0] m_ar_ready;
  logic  [NP-1:0] m_r_valid;
  id_t   [NP-1:0] m_r_id;
  data_t [NP-1:0] m_r_data;
  logic  [NP-1:0] m_r_last;
  logic  [NP-1:0] m_r_ready;

  // accepted requests per port, read by the port model and the scoreboard
  id_t   rec_id   [NP][DEPTH];
  addr_t rec_addr [NP][DEPTH];
  len_t  rec_len  [NP][DEPTH];
  int    wr_ptr [NP];
  int    mdl_ptr [NP];
  int    mdl_beat [NP];
  int    taken_cnt [NP];
  int    seen_taken [NP];
  int    sb_ptr [NP];
  int    sb_beat [NP];
  // expected slot state from the push and pop rule
  int    sb_cnt [NS];
  int    sb_port [NS];
  int    lock_port;
  int    issued;
  int    ar_done;
  int    beat_cnt;
  int    mismatch_cnt;
  int    other_cnt;

  rd_demux_top i_rd_demux_top (
    .clk_i (clk), .reset_i (reset),
    .s_ar_valid_i (s_ar_valid), .s_ar_id_i (s_ar_id), .s_ar_addr_i (s_ar_addr),
    .s_ar_len_i (s_ar_len), .s_ar_sel_i (s_ar_sel), .s_ar_ready_o (s_ar_ready),
    .s_r_valid_o (s_r_valid), .s_r_id_o (s_r_id), .s_r_data_o (s_r_data),
    .s_r_last_o (s_r_last), .s_r_ready_i (s_r_ready),
    .m_ar_valid_o (m_ar_valid), .m_ar_id_o (m_ar_id), .m_ar_addr_o (m_ar_addr),
    .m_ar_len_o (m_ar_len), .m_ar_ready_i (m_ar_ready),
    .m_r_valid_i (m_r_valid), .m_r_id_i (m_r_id), .m_r_data_i (m_r_data),
    .m_r_last_i (m_r_last), .m_r_ready_o (m_r_ready)
  );

  bind rd_demux_top rd_demux_chk #(.NUM_PORTS (NUM_PORTS)) i_rd_demux_chk (
    .clk_i (clk_i), .reset_i (reset_i),
    .m_ar_valid_i (m_ar_valid_o), .m_ar_ready_i (m_ar_ready_i), .m_ar_id_i (m_ar_id_o),
    .m_ar_addr_i (m_ar_addr_o), .m_ar_len_i (m_ar_len_o), .m_r_ready_i (m_r_ready_o),
    .s_r_valid_i (s_r_valid_o), .s_r_ready_i (s_r_ready_i), .s_r_id_i (s_r_id_o),
    .s_r_data_i (s_r_data_o), .s_r_last_i (s_r_last_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  task automatic flag_mismatch(string sig, logic [31:0] exp_val, logic [31:0] got_val);
    mismatch_cnt++;
    $display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, sig, exp_val, got_val);
  endtask

  task automatic note_failure(string msg);
    other_cnt++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // port number in the top nibble keeps beats of different ports apart
  function automatic data_t make_beat_data(int port, addr_t addr, int beat);
    return (addr + data_t'(beat * 4)) ^ (data_t'(port) << 28);
  endfunction

  function automatic bit all_drained();
    for (int p = 0; p < NP; p++) begin
      if (sb_ptr[p] != wr_ptr[p]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // offer one request and hold it until the handshake
  task automatic issue_ar(id_t id, port_sel_t sel);
    s_ar_valid = 1'b1;
    s_ar_id    = id;
    s_ar_sel   = sel;
    s_ar_addr  = addr_t'($urandom) & ~addr_t'(3);
    s_ar_len   = len_t'($urandom % 8);
    issued++;
    do @(negedge clk); while (ar_done != issued);
    s_ar_valid = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
  endtask

  // ------------------------------------------------------------------
  // master port models and slave ready driven on the falling edge
  // ------------------------------------------------------------------

  always @(negedge clk) begin : drive_edge
    int idx;
    if (!reset) begin
      s_r_ready = ($urandom % 4) != 0;
      for (int p = 0; p < NP; p++) begin
        m_ar_ready[p] = ($urandom % 3) != 0;
        // a beat not yet taken stays as it is
        if (!m_r_valid[p] || seen_taken[p] != taken_cnt[p]) begin
          seen_taken[p] = taken_cnt[p];
          idx = mdl_ptr[p] % DEPTH;
          if (mdl_ptr[p] != wr_ptr[p] && ($urandom % 3) != 0) begin
            m_r_valid[p] = 1'b1;
            m_r_id[p]    = rec_id[p][idx];
            m_r_data[p]  = make_beat_data(p, rec_addr[p][idx], mdl_beat[p]);
            m_r_last[p]  = (mdl_beat[p] == rec_len[p][idx]);
          end else begin
            m_r_valid[p] = 1'b0;
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // checks and bookkeeping on the rising edge
  // ------------------------------------------------------------------

  always @(posedge clk) begin : check_edge
    int    slot;
    int    src;
    int    idx;
    logic  admit;
    data_t exp_data;
    if (!reset) begin
      // slave and port handshakes happen together on both channels
      assert ((s_ar_valid && s_ar_ready) == (|(m_ar_valid & m_ar_ready))) else
        note_failure("s_ar_ready_o does not follow the ready of the selected port");
      assert ((s_r_valid && s_r_ready) == (|(m_r_valid & m_r_ready))) else
        note_failure("m_r_ready_o does not follow the slave R handshake");
      for (int p = 0; p < NP; p++) begin
        if (m_ar_valid[p] && m_ar_ready[p]) begin
          rec_id[p][wr_ptr[p] % DEPTH]   = s_ar_id;
          rec_addr[p][wr_ptr[p] % DEPTH] = s_ar_addr;
          rec_len[p][wr_ptr[p] % DEPTH]  = s_ar_len;
          wr_ptr[p]++;
        end
      end
      if (s_ar_valid && s_ar_ready) begin
        slot = int'(s_ar_id) % NS;
        assert ($onehot(m_ar_valid)) else
          note_failure("not exactly one m_ar_valid_o at handshake");
        assert (m_ar_valid[s_ar_sel]) else
          flag_mismatch("m_ar_valid_o", 32'(1) << s_ar_sel, 32'(m_ar_valid));
        assert (m_ar_id[s_ar_sel] == s_ar_id) else
          flag_mismatch("m_ar_id_o", 32'(s_ar_id), 32'(m_ar_id[s_ar_sel]));
        assert (m_ar_addr[s_ar_sel] == s_ar_addr) else
          flag_mismatch("m_ar_addr_o", s_ar_addr, m_ar_addr[s_ar_sel]);
        assert (m_ar_len[s_ar_sel] == s_ar_len) else
          flag_mismatch("m_ar_len_o", 32'(s_ar_len), 32'(m_ar_len[s_ar_sel]));
        // same slot only to the same port, and never past a full slot
        admit = (sb_cnt[slot] == 0) || (sb_port[slot] == int'(s_ar_sel));
        for (int s = 0; s < NS; s++) begin
          if (sb_cnt[s] == CNT_MAX) admit = 1'b0;
        end
        assert (admit) else
          note_failure($sformatf("AR id %0h to port %0d accepted while blocked",
                                 s_ar_id, s_ar_sel));
        sb_cnt[slot]++;
        sb_port[slot] = int'(s_ar_sel);
        ar_done++;
      end
      if (s_r_valid && s_r_ready) begin
        beat_cnt++;
        src = lock_port;
        if (src < 0) begin
          // look for the port that owns this first beat
          for (int p = NP - 1; p >= 0; p--) begin
            idx = sb_ptr[p] % DEPTH;
            if (sb_ptr[p] != wr_ptr[p] && s_r_id == rec_id[p][idx] &&
                s_r_data == make_beat_data(p, rec_addr[p][idx], 0) &&
                s_r_last == (rec_len[p][idx] == 0)) src = p;
          end
        end
        assert (src >= 0) else
          note_failure($sformatf("R beat id %0h data %0h matches no pending burst",
                                 s_r_id, s_r_data));
        if (src >= 0) begin
          idx = sb_ptr[src] % DEPTH;
          exp_data = make_beat_data(src, rec_addr[src][idx], sb_beat[src]);
          assert (s_r_id == rec_id[src][idx]) else
            flag_mismatch("s_r_id_o", 32'(rec_id[src][idx]), 32'(s_r_id));
          assert (s_r_data == exp_data) else
            flag_mismatch("s_r_data_o", exp_data, s_r_data);
          assert (s_r_last == (sb_beat[src] == rec_len[src][idx])) else
            flag_mismatch("s_r_last_o", 32'(sb_beat[src] == rec_len[src][idx]), 32'(s_r_last));
          if (s_r_last) begin
            slot = int'(s_r_id) % NS;
            assert (sb_cnt[slot] > 0) else
              note_failure("last beat for a slot with nothing in flight");
            if (sb_cnt[slot] > 0) sb_cnt[slot]--;
            sb_ptr[src]++;
            sb_beat[src] = 0;
            lock_port = -1;
          end else begin
            sb_beat[src]++;
            lock_port = src;
          end
        end
      end
      // port models step on their own handshakes
      for (int p = 0; p < NP; p++) begin
        if (m_r_valid[p] && m_r_ready[p]) begin
          taken_cnt[p]++;
          if (m_r_last[p]) begin
            mdl_ptr[p]++;
            mdl_beat[p] = 0;
          end else begin
            mdl_beat[p]++;
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------

  initial begin : stimulus
    id_t         prev_id;
    port_sel_t   prev_sel;
    int          phase;
    int unsigned chk_errs;
    void'($urandom(52662));
    reset      = 1'b1;
    s_ar_valid = 1'b0;
    s_ar_id    = '0;
    s_ar_addr  = '0;
    s_ar_len   = '0;
    s_ar_sel   = '0;
    s_r_ready  = 1'b0;
    m_ar_ready = '0;
    m_r_valid  = '0;
    m_r_id     = '0;
    m_r_data   = '0;
    m_r_last   = '0;
    for (int p = 0; p < NP; p++) begin
      wr_ptr[p]     = 0;
      mdl_ptr[p]    = 0;
      mdl_beat[p]   = 0;
      taken_cnt[p]  = 0;
      seen_taken[p] = 0;
      sb_ptr[p]     = 0;
      sb_beat[p]    = 0;
    end
    for (int s = 0; s < NS; s++) begin
      sb_cnt[s]  = 0;
      sb_port[s] = 0;
    end
    lock_port    = -1;
    issued       = 0;
    ar_done      = 0;
    beat_cnt     = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    prev_id      = '0;
    prev_sel     = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    assert (m_ar_valid == '0 && !s_r_valid && !s_ar_ready) else
      note_failure("valid or ready outputs high after reset");
    @(negedge clk);
    for (int n = 0; n < NUM_AR; n++) begin
      phase = n % 50;
      if (phase > 0 && phase < 10) begin
        // run of one id to one port fills its slot
      end else if (phase >= 20 && phase < 25) begin
        // same slot to another port waits for the drain
        prev_id  = (id_t'($urandom) & ~id_t'(NS - 1)) | (prev_id & id_t'(NS - 1));
        prev_sel = port_sel_t'((int'(prev_sel) + 1) % NP);
      end else begin
        prev_id  = id_t'($urandom);
        prev_sel = port_sel_t'($urandom % NP);
      end
      issue_ar(prev_id, prev_sel);
    end
    while (!all_drained()) @(negedge clk);
    repeat (10) @(negedge clk);
    chk_errs = i_rd_demux_top.i_rd_demux_chk.fail_cnt;
    $display("summary: ARs=%0d beats=%0d mismatches=%0d other=%0d assertion_fails=%0d",
             ar_done, beat_cnt, mismatch_cnt, other_cnt, chk_errs);
    if (mismatch_cnt == 0 && other_cnt == 0 && chk_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // end the run after 400 cycles per request
  initial begin : watchdog
    #(NUM_AR * 400 * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", NUM_AR * 400);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== project.f ====
common/demux_cfg_pkg.sv
common/axi_rd_pkg.sv
rtl/id_slot.sv
rd_demux/ar_route.sv
rd_demux/r_merge.sv
rd_demux/rd_demux_top.sv
verif/rd_demux_chk.sv
verif/tb_rd_demux.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_rd_demux
FILELIST := project.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := Simulation completed successfully
RUN_ARGS := +verilator+error+limit+1000

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
